//--- Makefile
SOURCES = hw/i2c_pkg.sv hw/i2c_bit_engine.sv hw/i2c_transfer_fsm.sv hw/i2c_master.sv \
          verif/i2c_target_model.sv verif/i2c_master_assert.sv verif/tb_i2c_master.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_i2c_master: compile.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_i2c_master -f compile.f

run: obj_dir/Vtb_i2c_master
	./obj_dir/Vtb_i2c_master > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "Simulation FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- compile.f
hw/i2c_pkg.sv
hw/i2c_bit_engine.sv
hw/i2c_transfer_fsm.sv
hw/i2c_master.sv
verif/i2c_target_model.sv
verif/i2c_master_assert.sv
verif/tb_i2c_master.sv

//--- hw/i2c_bit_engine.sv
`timescale 1ns/100ps

module i2c_bit_engine (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic [i2c_pkg::div_width-1:0]   divider,
    input  logic                            scl_in,
    input  logic                            sda_in,
    output logic                            scl_pull,
    output logic                            sda_pull,
    i2c_bit_if.engine                       bus
);

    logic [i2c_pkg::div_width-1:0]  div_count;
    logic                           tick;
    logic [1:0]                     phase;
    logic [1:0]                     scl_sync;
    logic [1:0]                     sda_sync;
    logic                           step;
    logic                           stretch;

    //////////////////////////////////////////////////
    // Divider tick, one every divider+1 clocks
    //////////////////////////////////////////////////

    assign tick = (div_count >= divider);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            div_count <= '0;
        end else if (tick) begin
            div_count <= '0;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    // Bus lines into the clock domain, idle bus reads high
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
        end else begin
            scl_sync <= {scl_sync[0], scl_in};
            sda_sync <= {sda_sync[0], sda_in};
        end
    end

    //////////////////////////////////////////////////
    // Four phases per symbol
    //////////////////////////////////////////////////

    // No stepping in the done cycle, the command there is stale
    assign step = tick && bus.cmd_valid && !bus.done;

    // Target holding SCL low stalls the high phase
    assign stretch = (phase == 2'd2) && !scl_sync[1];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            phase    <= 2'd0;
            scl_pull <= 1'b0;
            sda_pull <= 1'b0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (tick && !bus.cmd_valid) begin
                // Sequencer idle or aborted, let go of both lines
                phase    <= 2'd0;
                scl_pull <= 1'b0;
                sda_pull <= 1'b0;
            end else if (step && !stretch) begin
                phase <= phase + 2'd1;
                case (phase)
                    2'd0: begin
                        // SDA set up while SCL is still low
                        case (bus.cmd)
                            i2c_pkg::cmd_write_bit: sda_pull <= !bus.tx_bit;
                            i2c_pkg::cmd_stop:      sda_pull <= 1'b1;
                            default:                sda_pull <= 1'b0;
                        endcase
                    end
                    2'd1: begin
                        scl_pull <= 1'b0;
                    end
                    2'd2: begin
                        // Start and stop edges on SDA with SCL high
                        if (bus.cmd == i2c_pkg::cmd_start) begin
                            sda_pull <= 1'b1;
                        end else if (bus.cmd == i2c_pkg::cmd_stop) begin
                            sda_pull <= 1'b0;
                        end
                    end
                    default: begin
                        // SCL stays released after a stop
                        scl_pull <= (bus.cmd != i2c_pkg::cmd_stop);
                        bus.done <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Sampled in the SCL high phase, valid with done
    always_ff @(posedge clock) begin
        if (step && !stretch && (phase == 2'd2)) begin
            bus.rx_bit <= sda_sync[1];
        end
    end

endmodule

//--- hw/i2c_master.sv
`timescale 1ns/100ps

module i2c_master (
    input  logic                                clock,
    input  logic                                reset_n,
    input  logic                                enable,
    input  logic                                read_write,
    input  logic [i2c_pkg::data_width-1:0]      mosi_data,
    input  logic [i2c_pkg::data_width-1:0]      register_address,
    input  logic [i2c_pkg::addr_width-1:0]      device_address,
    input  logic [i2c_pkg::div_width-1:0]       divider,
    input  logic                                scl_in,
    input  logic                                sda_in,
    output logic [i2c_pkg::data_width-1:0]      miso_data,
    output logic                                busy,
    output logic                                scl_pull,
    output logic                                sda_pull
);

    // Symbol handshake between sequencer and engine
    i2c_bit_if bit_bus ();

    i2c_transfer_fsm transfer_fsm_inst (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .mosi_data        (mosi_data),
        .register_address (register_address),
        .device_address   (device_address),
        .miso_data        (miso_data),
        .busy             (busy),
        .bus              (bit_bus.sequencer)
    );

    // Open drain, pull enables only
    i2c_bit_engine bit_engine_inst (
        .clock    (clock),
        .reset_n  (reset_n),
        .divider  (divider),
        .scl_in   (scl_in),
        .sda_in   (sda_in),
        .scl_pull (scl_pull),
        .sda_pull (sda_pull),
        .bus      (bit_bus.engine)
    );

endmodule

//--- hw/i2c_pkg.sv
package i2c_pkg;

    // Device address, then byte width for register address and data
    localparam int addr_width = 7;
    localparam int data_width = 8;

    // SCL divider value
    localparam int div_width = 16;

    // Bus symbols issued by the sequencer
    typedef enum logic [2:0] {
        cmd_start     = 3'd0,
        cmd_write_bit = 3'd1,
        cmd_read_bit  = 3'd2,
        cmd_stop      = 3'd3
    } bus_cmd_t;

endpackage

`timescale 1ns/100ps

// One bus symbol in flight between sequencer and bit engine
interface i2c_bit_if;

    logic               cmd_valid;
    i2c_pkg::bus_cmd_t  cmd;
    logic               tx_bit;
    logic               done;
    logic               rx_bit;

    modport sequencer (
        output cmd_valid,
        output cmd,
        output tx_bit,
        input  done,
        input  rx_bit
    );

    modport engine (
        input  cmd_valid,
        input  cmd,
        input  tx_bit,
        output done,
        output rx_bit
    );

endinterface

//--- hw/i2c_transfer_fsm.sv
`timescale 1ns/100ps

module i2c_transfer_fsm (
    input  logic                                clock,
    input  logic                                reset_n,
    input  logic                                enable,
    input  logic                                read_write,
    input  logic [i2c_pkg::data_width-1:0]      mosi_data,
    input  logic [i2c_pkg::data_width-1:0]      register_address,
    input  logic [i2c_pkg::addr_width-1:0]      device_address,
    output logic [i2c_pkg::data_width-1:0]      miso_data,
    output logic                                busy,
    i2c_bit_if.sequencer                        bus
);

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_addr_w,
        st_check_ack,
        st_reg_addr,
        st_write_data,
        st_restart,
        st_addr_r,
        st_read_data,
        st_send_nack,
        st_stop
    } state_t;

    state_t                                 state;
    state_t                                 post_state;
    logic                                   saved_read;
    logic [$clog2(i2c_pkg::data_width)-1:0] bit_count;
    logic                                   last_bit;
    logic                                   accept;
    logic                                   byte_out;
    logic                                   ack_ok;
    logic [i2c_pkg::data_width-1:0]         tx_shift;
    logic [i2c_pkg::data_width-1:0]         next_byte;
    logic [i2c_pkg::addr_width-1:0]         saved_device;
    logic [i2c_pkg::data_width-1:0]         saved_register;
    logic [i2c_pkg::data_width-1:0]         saved_data;

    assign accept   = (state == st_idle) && enable;
    assign byte_out = (state == st_addr_w) || (state == st_reg_addr) ||
                      (state == st_write_data) || (state == st_addr_r);
    assign last_bit = (int'(bit_count) == i2c_pkg::data_width - 1);
    assign ack_ok   = (state == st_check_ack) && bus.done && !bus.rx_bit;

    // MSB first
    assign bus.tx_bit = tx_shift[i2c_pkg::data_width-1];

    //////////////////////////////////////////////////
    // Byte staging
    //////////////////////////////////////////////////

    // All ones leaves SDA released for the closing NACK
    always_comb begin
        case (post_state)
            st_reg_addr:   next_byte = saved_register;
            st_write_data: next_byte = saved_data;
            st_restart:    next_byte = {saved_device, 1'b1};
            default:       next_byte = '1;
        endcase
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            saved_device   <= device_address;
            saved_register <= register_address;
            saved_data     <= mosi_data;
            tx_shift       <= {device_address, 1'b0};
        end else if (ack_ok) begin
            tx_shift <= next_byte;
        end else if (byte_out && bus.done) begin
            tx_shift <= {tx_shift[i2c_pkg::data_width-2:0], 1'b1};
        end
    end

    //////////////////////////////////////////////////
    // Transaction sequence
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state         <= st_idle;
            post_state    <= st_idle;
            saved_read    <= 1'b0;
            bit_count     <= '0;
            busy          <= 1'b0;
            miso_data     <= '0;
            bus.cmd_valid <= 1'b0;
            bus.cmd       <= i2c_pkg::cmd_stop;
        end else begin
            case (state)
                st_idle: begin
                    if (enable) begin
                        saved_read    <= read_write;
                        busy          <= 1'b1;
                        bus.cmd_valid <= 1'b1;
                        bus.cmd       <= i2c_pkg::cmd_start;
                        state         <= st_start;
                    end
                end
                st_start, st_restart: begin
                    if (bus.done) begin
                        bit_count <= '0;
                        bus.cmd   <= i2c_pkg::cmd_write_bit;
                        state     <= (state == st_start) ? st_addr_w : st_addr_r;
                    end
                end
                st_addr_w, st_reg_addr, st_write_data, st_addr_r: begin
                    if (bus.done) begin
                        if (last_bit) begin
                            bus.cmd <= i2c_pkg::cmd_read_bit;
                            state   <= st_check_ack;
                            case (state)
                                st_addr_w:     post_state <= st_reg_addr;
                                st_reg_addr:   post_state <= saved_read ? st_restart
                                                                        : st_write_data;
                                st_write_data: post_state <= st_stop;
                                default:       post_state <= st_read_data;
                            endcase
                        end else begin
                            bit_count <= bit_count + 1'b1;
                        end
                    end
                end
                st_check_ack: begin
                    if (bus.done) begin
                        if (bus.rx_bit) begin
                            // NACK, drop out without a stop
                            busy          <= 1'b0;
                            bus.cmd_valid <= 1'b0;
                            state         <= st_idle;
                        end else begin
                            bit_count <= '0;
                            state     <= post_state;
                            case (post_state)
                                st_stop:      bus.cmd <= i2c_pkg::cmd_stop;
                                st_restart:   bus.cmd <= i2c_pkg::cmd_start;
                                st_read_data: bus.cmd <= i2c_pkg::cmd_read_bit;
                                default:      bus.cmd <= i2c_pkg::cmd_write_bit;
                            endcase
                        end
                    end
                end
                st_read_data: begin
                    if (bus.done) begin
                        miso_data <= {miso_data[i2c_pkg::data_width-2:0], bus.rx_bit};
                        if (last_bit) begin
                            bus.cmd <= i2c_pkg::cmd_write_bit;
                            state   <= st_send_nack;
                        end else begin
                            bit_count <= bit_count + 1'b1;
                        end
                    end
                end
                st_send_nack: begin
                    if (bus.done) begin
                        bus.cmd <= i2c_pkg::cmd_stop;
                        state   <= st_stop;
                    end
                end
                default: begin
                    if (bus.done) begin
                        busy          <= 1'b0;
                        bus.cmd_valid <= 1'b0;
                        state         <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

//--- verif/i2c_master_assert.sv
`timescale 1ns/100ps

module i2c_master_assert (
    input logic              clock,
    input logic              reset_n,
    input logic              scl,
    input logic              sda,
    input logic              busy,
    input logic              cmd_valid,
    input logic              done,
    input i2c_pkg::bus_cmd_t cmd
);

    // SDA may only move under a high SCL for start and stop
    assert property (@(posedge clock) disable iff (!reset_n)
        (scl && $past(scl) && (sda != $past(sda))) |->
        (cmd_valid && (cmd == i2c_pkg::cmd_start || cmd == i2c_pkg::cmd_stop)))
        else $error("SDA changed while SCL high outside a start or stop");

    assert property (@(posedge clock) !reset_n |=> !busy)
        else $error("busy high during or right after reset");

    assert property (@(posedge clock) disable iff (!reset_n) done |-> cmd_valid)
        else $error("done pulsed with no command in flight");

endmodule

bind i2c_master i2c_master_assert master_assert_inst (
    .clock     (clock),
    .reset_n   (reset_n),
    .scl       (scl_in),
    .sda       (sda_in),
    .busy      (busy),
    .cmd_valid (bit_bus.cmd_valid),
    .done      (bit_bus.done),
    .cmd       (bit_bus.cmd)
);

//--- verif/i2c_target_model.sv
`timescale 1ns/100ps

module i2c_target_model #(
    parameter logic [i2c_pkg::addr_width-1:0] device_address = 7'h48,
    parameter int stretch_ns = 350
) (
    input  logic scl,
    input  logic sda,
    input  logic stretch_enable,
    output logic scl_pull,
    output logic sda_pull
);

    typedef enum logic [2:0] {
        mode_idle,
        mode_addr,
        mode_reg,
        mode_wdata,
        mode_rdata,
        mode_ignore
    } mode_t;

    logic [7:0] memory [0:255];
    mode_t      mode;
    logic [7:0] shift_in;
    logic [7:0] tx_byte;
    logic [7:0] reg_ptr;
    logic       read_mode;
    logic [7:0] last_write_reg;
    logic [7:0] last_write_data;
    logic       scl_last;
    logic       sda_last;
    int         bit_index;
    int         address_acks;

    initial begin
        mode         = mode_idle;
        scl_pull     = 1'b0;
        sda_pull     = 1'b0;
        shift_in     = '0;
        tx_byte      = '0;
        reg_ptr      = '0;
        read_mode    = 1'b0;
        scl_last     = 1'b1;
        sda_last     = 1'b1;
        bit_index    = 0;
        address_acks = 0;
    end

    // ACK slot opens after 8 bits, closes after the 9th clock
    task automatic falling_scl();
        if (mode == mode_rdata) begin
            if (bit_index >= 1 && bit_index <= 7) begin
                sda_pull = !tx_byte[7 - bit_index];
            end else begin
                sda_pull = 1'b0;
                if (bit_index >= 9) begin
                    mode = mode_ignore;
                end
            end
        end else if (mode == mode_addr || mode == mode_reg || mode == mode_wdata) begin
            if (bit_index == 8) begin
                if (mode == mode_addr) begin
                    if (shift_in[7:1] == device_address) begin
                        sda_pull     = 1'b1;
                        read_mode    = shift_in[0];
                        address_acks = address_acks + 1;
                    end else begin
                        mode = mode_ignore;
                    end
                end else if (mode == mode_reg) begin
                    reg_ptr  = shift_in;
                    sda_pull = 1'b1;
                end else begin
                    memory[reg_ptr] = shift_in;
                    last_write_reg  = reg_ptr;
                    last_write_data = shift_in;
                    sda_pull        = 1'b1;
                end
            end else if (bit_index == 9) begin
                sda_pull  = 1'b0;
                bit_index = 0;
                if (mode == mode_addr && read_mode) begin
                    mode     = mode_rdata;
                    tx_byte  = memory[reg_ptr];
                    sda_pull = !tx_byte[7];
                end else if (mode == mode_addr) begin
                    mode = mode_reg;
                end else if (mode == mode_reg) begin
                    mode = mode_wdata;
                end else begin
                    mode = mode_ignore;
                end
            end
        end else begin
            sda_pull = 1'b0;
        end
    endtask

    always @(scl or sda) begin
        if (scl && scl_last && sda_last && !sda) begin
            // Start or repeated start
            mode      = mode_addr;
            bit_index = 0;
            sda_pull  = 1'b0;
        end else if (scl && scl_last && !sda_last && sda) begin
            mode     = mode_idle;
            sda_pull = 1'b0;
        end else if (scl && !scl_last) begin
            if (mode != mode_idle && mode != mode_ignore) begin
                if (bit_index < 8) begin
                    shift_in = {shift_in[6:0], sda};
                end
                bit_index = bit_index + 1;
            end
        end else if (!scl && scl_last) begin
            falling_scl();
        end
        scl_last = scl;
        sda_last = sda;
    end

    // Hold SCL low a while after each falling edge
    always @(negedge scl) begin
        if (stretch_enable && mode != mode_idle) begin
            scl_pull = 1'b1;
            #(stretch_ns);
            scl_pull = 1'b0;
        end
    end

endmodule

//--- verif/tb_i2c_master.sv
`timescale 1ns/100ps

module tb_i2c_master;

    localparam logic [6:0] target_address = 7'h48;
    localparam int wait_limit = 50000;
    localparam int random_rows = 24;

    typedef struct packed {
        logic        rw;
        logic [6:0]  dev;
        logic [7:0]  reg_addr;
        logic [7:0]  wdata;
        logic        stretch;
        logic [15:0] div;
        logic [7:0]  exp_miso;
        logic        exp_ack;
        logic [7:0]  exp_mem;
    } row_t;

    logic        clock = 1'b0;
    logic        reset_n;
    logic        enable;
    logic        read_write;
    logic [7:0]  mosi_data;
    logic [7:0]  register_address;
    logic [6:0]  device_address;
    logic [15:0] divider;
    logic        stretch_enable;
    logic [7:0]  miso_data;
    logic        busy;
    logic        master_scl_pull;
    logic        master_sda_pull;
    logic        target_scl_pull;
    logic        target_sda_pull;
    logic        scl_line;
    logic        sda_line;
    row_t        rows[$];
    logic [7:0]  model_mem [0:255];
    logic [7:0]  model_miso;
    logic [31:0] rng_state;
    logic        timed_out;
    int          errors;
    int          timeouts;

    // Wired-AND of the open-drain lines
    assign scl_line = !(master_scl_pull || target_scl_pull);
    assign sda_line = !(master_sda_pull || target_sda_pull);

    always #50 clock = ~clock;

    i2c_master i2c_master_inst (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .mosi_data        (mosi_data),
        .register_address (register_address),
        .device_address   (device_address),
        .divider          (divider),
        .scl_in           (scl_line),
        .sda_in           (sda_line),
        .miso_data        (miso_data),
        .busy             (busy),
        .scl_pull         (master_scl_pull),
        .sda_pull         (master_sda_pull)
    );

    i2c_target_model #(.device_address(target_address)) target_inst (
        .scl            (scl_line),
        .sda            (sda_line),
        .stretch_enable (stretch_enable),
        .scl_pull       (target_scl_pull),
        .sda_pull       (target_sda_pull)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] fill_value(input int addr);
        return 8'(addr * 37) ^ 8'h5b;
    endfunction

    // Expected values follow the shadow memory as rows are added
    task automatic add_row(input logic rw, input logic [6:0] dev, input logic [7:0] reg_addr,
                           input logic [7:0] data, input logic stretch, input logic [15:0] div);
        row_t row;
        logic ack;
        ack = (dev == target_address);
        if (ack && !rw) begin
            model_mem[reg_addr] = data;
        end
        if (ack && rw) begin
            model_miso = model_mem[reg_addr];
        end
        row = '{rw, dev, reg_addr, data, stretch, div, model_miso, ack, model_mem[reg_addr]};
        rows.push_back(row);
    endtask

    task automatic wait_for_busy(input logic level, input int row_index);
        int count;
        count = 0;
        @(negedge clock);
        while (busy !== level && count < wait_limit) begin
            @(negedge clock);
            count++;
        end
        if (busy !== level) begin
            $display("Timeout in row %0d, busy never went to %0d", row_index, level);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    // An aborted transfer lets go of SCL on the next divider tick
    task automatic settle_bus();
        int count;
        count = 0;
        while (!(scl_line && sda_line) && count < wait_limit) begin
            @(negedge clock);
            count++;
        end
    endtask

    task automatic check_row(input int idx, input row_t row, input logic got_ack);
        assert (miso_data == row.exp_miso) else begin
            $display("ERR miso_data row %0d expected %h got %h", idx, row.exp_miso, miso_data);
            errors++;
        end
        assert (got_ack == row.exp_ack) else begin
            $display("ERR address_ack row %0d expected %h got %h", idx, row.exp_ack, got_ack);
            errors++;
        end
        assert (target_inst.memory[row.reg_addr] == row.exp_mem) else begin
            $display("ERR memory[%h] row %0d expected %h got %h", row.reg_addr, idx,
                     row.exp_mem, target_inst.memory[row.reg_addr]);
            errors++;
        end
        if (!row.rw && row.exp_ack) begin
            assert (target_inst.last_write_reg == row.reg_addr) else begin
                $display("ERR last_write_reg row %0d expected %h got %h", idx, row.reg_addr,
                         target_inst.last_write_reg);
                errors++;
            end
            assert (target_inst.last_write_data == row.wdata) else begin
                $display("ERR last_write_data row %0d expected %h got %h", idx, row.wdata,
                         target_inst.last_write_data);
                errors++;
            end
        end
        assert (scl_line && sda_line) else begin
            $display("Bus lines not released after row %0d", idx);
            errors++;
        end
    endtask

    initial begin
        row_t row;
        int   acks_before;
        reset_n          = 1'b0;
        enable           = 1'b0;
        read_write       = 1'b0;
        mosi_data        = '0;
        register_address = '0;
        device_address   = '0;
        divider          = 16'd3;
        stretch_enable   = 1'b0;
        errors           = 0;
        timeouts         = 0;
        timed_out        = 1'b0;
        model_miso       = '0;
        rng_state        = 32'h9028;
        for (int i = 0; i < 256; i++) begin
            model_mem[i]          = fill_value(i);
            target_inst.memory[i] = fill_value(i);
        end

        ////////////////////////////////////////////////
        // Stimulus table
        ////////////////////////////////////////////////
        add_row(1'b0, target_address, 8'h10, 8'h3c, 1'b0, 16'd3);
        add_row(1'b1, target_address, 8'h10, 8'h00, 1'b0, 16'd3);
        add_row(1'b1, target_address, 8'h22, 8'h00, 1'b0, 16'd1);
        add_row(1'b0, 7'h31, 8'h10, 8'hff, 1'b0, 16'd3);
        add_row(1'b1, 7'h31, 8'h10, 8'h00, 1'b0, 16'd3);
        add_row(1'b1, target_address, 8'h10, 8'h00, 1'b0, 16'd0);
        add_row(1'b0, target_address, 8'h55, 8'ha7, 1'b1, 16'd2);
        add_row(1'b1, target_address, 8'h55, 8'h00, 1'b1, 16'd2);
        add_row(1'b1, target_address, 8'h23, 8'h00, 1'b1, 16'd4);
        for (int n = 0; n < random_rows; n++) begin
            rng_state = xorshift(rng_state);
            add_row(rng_state[0], (rng_state[3:1] == 3'd0) ? 7'h2a : target_address,
                    rng_state[15:8], rng_state[23:16], rng_state[4], {13'd0, rng_state[26:24]});
        end

        repeat (5) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        assert (!busy && !master_scl_pull && !master_sda_pull && miso_data == 8'h00) else begin
            $display("ERR reset busy %h scl_pull %h sda_pull %h miso_data %h",
                     busy, master_scl_pull, master_sda_pull, miso_data);
            errors++;
        end

        foreach (rows[i]) begin
            if (!timed_out) begin
                row = rows[i];
                acks_before = target_inst.address_acks;
                @(posedge clock);
                read_write       <= row.rw;
                device_address   <= row.dev;
                register_address <= row.reg_addr;
                mosi_data        <= row.wdata;
                divider          <= row.div;
                stretch_enable   <= row.stretch;
                enable           <= 1'b1;
                wait_for_busy(1'b1, i);
                @(posedge clock);
                enable <= 1'b0;
                if (!timed_out) begin
                    wait_for_busy(1'b0, i);
                end
                if (!timed_out) begin
                    settle_bus();
                    check_row(i, row, target_inst.address_acks != acks_before);
                end
            end
        end

        // Absent-device rows must have left the memory alone
        for (int i = 0; i < 256; i++) begin
            assert (target_inst.memory[i] == model_mem[i]) else begin
                $display("ERR memory[%h] expected %h got %h", i[7:0], model_mem[i],
                         target_inst.memory[i]);
                errors++;
            end
        end

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
